/* flist.f */
+incdir+source
source/core_pkg.sv
source/core_settings_regs.sv
source/video_output.sv
source/link_video_dac.sv
source/core_top.sv
tests/core_top_assertions.sv
tests/core_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module core_top_tb \
  -f flist.f -o core_top_sim &&
./obj_dir/core_top_sim | tee /dev/stderr | grep -q '^Simulation PASSED$' &&
echo "run_sim: run passed" ||
{ echo "run_sim: run failed"; exit 1; }

/* tests/core_top_tb.sv */
/*
  Table-driven testbench for the console glue logic. Rows drive the
  bridge and the pixel inputs, one row per clock, and a reference
  model built from the register map and video rules predicts outputs.
*/

`timescale 1ns/10ps

`include "core_settings.svh"

module core_top_tb
  import core_pkg::*;
();

  localparam logic [1:0] kind_pix = 2'd0;
  localparam logic [1:0] kind_wr  = 2'd1;
  localparam logic [1:0] kind_rd  = 2'd2;

  // greys hit every luma band, primaries check the weights
  localparam logic [23:0] colours [11] = '{
    24'h000000, 24'h202020, 24'h303030, 24'h505050, 24'h707070, 24'ha0a0a0,
    24'hd0d0d0, 24'hffffff, 24'hff0000, 24'h00ff00, 24'h0000ff
  };

  typedef struct packed {
    logic [1:0]  kind;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp_rd;
    logic [23:0] rgb;
    logic [3:0]  ctl;      // hblank, vblank, hsync, vsync
  } row_t;

  logic        clk_74a;
  logic        pll_core_locked;
  logic [31:0] bridge_addr;
  logic        bridge_rd;
  logic        bridge_wr;
  logic [31:0] bridge_wr_data;
  logic [31:0] bridge_rd_data;
  pixel_word_u pix_rgb;
  logic        pix_hblank;
  logic        pix_vblank;
  logic        pix_hsync;
  logic        pix_vsync;
  pixel_word_u video_rgb;
  logic        video_de;
  logic        video_hs;
  logic        video_vs;
  logic        link_r270;
  logic        link_r330;
  logic        link_r470;
  logic        core_reset;

  row_t stim_table [$];

  // reference model state and the outputs expected after the next edge
  pixel_word_u exp_rgb;
  logic        exp_de;
  logic        exp_hs;
  logic        exp_vs;
  logic        exp_core_reset;
  logic [2:0]  exp_link;
  logic        prev_de;
  logic        prev_hs;
  logic        prev_vs;
  logic        hide_flag;
  int          hs_wait;
  int          hold_left;

  int value_errors;
  int other_errors;
  int checks;
  int reset_run;
  int reset_pulses;
  int cycle_count;
  int cycle_limit;

  core_top dut0 (.*);

  bind core_top core_top_assertions asserts0 (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs),
    .core_reset     (core_reset)
  );

  always #10 clk_74a = !clk_74a;

  always @(posedge clk_74a) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, the stimulus table did not finish", cycle_count);
      $display("Simulation FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // table building

  task automatic add_row(input logic [1:0] kind, input logic [31:0] addr,
                         input logic [31:0] data, input logic [31:0] exp_rd,
                         input logic [23:0] rgb, input logic [3:0] ctl);
    row_t r;
    r.kind   = kind;
    r.addr   = addr;
    r.data   = data;
    r.exp_rd = exp_rd;
    r.rgb    = rgb;
    r.ctl    = ctl;
    stim_table.push_back(r);
  endtask

  task automatic add_blank(input int n, input logic hs, input logic vs);
    repeat (n) add_row(kind_pix, 32'h0, 32'h0, 32'h0, 24'h0, {2'b11, hs, vs});
  endtask

  task automatic add_pixel(input logic [23:0] rgb);
    add_row(kind_pix, 32'h0, 32'h0, 32'h0, rgb, 4'b0000);
  endtask

  task automatic add_write(input logic [31:0] addr, input logic [31:0] data);
    add_row(kind_wr, addr, data, 32'h0, 24'h0, 4'b1100);
  endtask

  task automatic add_read(input logic [31:0] addr, input logic [31:0] expected);
    add_row(kind_rd, addr, 32'h0, expected, 24'h0, 4'b1100);
  endtask

  task automatic build_table();
    add_blank(2, 1'b0, 1'b0);
    // overscan flag write and readback
    add_write(`CORE_ADDR_OVERSCAN, 32'h1);
    add_read(`CORE_ADDR_OVERSCAN, 32'h1);
    add_read(32'h0000_0204, 32'h0);
    add_write(`CORE_ADDR_OVERSCAN, 32'hffff_fffe);
    add_read(`CORE_ADDR_OVERSCAN, 32'h0);
    add_write(`CORE_ADDR_OVERSCAN, 32'h1);
    add_read(`CORE_ADDR_OVERSCAN, 32'h1);
    // core reset hold
    add_write(`CORE_ADDR_RESET, 32'h0);
    add_blank(`CORE_RESET_HOLD_CYCLES + 4, 1'b0, 1'b0);
    // active line, then slot word with the flag set
    foreach (colours[i]) add_pixel(colours[i]);
    add_blank(3, 1'b0, 1'b0);
    add_write(`CORE_ADDR_OVERSCAN, 32'h0);
    for (int i = 0; i < 3; i++) add_pixel(colours[i + 4]);
    add_blank(3, 1'b0, 1'b0);
    // vblank alone also ends the active line
    add_pixel(24'h123456);
    add_row(kind_pix, 32'h0, 32'h0, 32'h0, 24'h654321, 4'b0100);
    add_blank(2, 1'b0, 1'b0);
    // sync pulses
    add_blank(2, 1'b1, 1'b0);
    add_blank(12, 1'b0, 1'b0);
    add_blank(2, 1'b0, 1'b1);
    add_blank(4, 1'b0, 1'b0);
    repeat (40) add_pixel(24'($urandom));
    add_blank(3, 1'b0, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // reference model

  // ladder code {r270, r330, r470} from the luma bands
  function automatic logic [2:0] ladder_for(input logic [23:0] rgb, input logic hb,
                                            input logic vb, input logic hs, input logic vs);
    int sum;
    int luma;
    sum = int'(`LUMA_WEIGHT_R) * int'(rgb[23:16]) + int'(`LUMA_WEIGHT_G) * int'(rgb[15:8])
        + int'(`LUMA_WEIGHT_B) * int'(rgb[7:0]);
    luma = (sum >> 12) & 15;
    if (hb || vb) return (hs || vs) ? 3'b000 : 3'b001;
    if (luma >= int'(`LUMA_LEVEL_5)) return 3'b110;
    if (luma >= int'(`LUMA_LEVEL_4)) return 3'b101;
    if (luma >= int'(`LUMA_LEVEL_3)) return 3'b011;
    if (luma >= int'(`LUMA_LEVEL_2)) return 3'b100;
    if (luma >= int'(`LUMA_LEVEL_1)) return 3'b010;
    return 3'b001;
  endfunction

  // step the model over the edge that samples the current inputs
  task automatic advance_model();
    logic de;
    de = !(pix_hblank || pix_vblank);
    exp_de = de;
    exp_rgb = '0;
    if (de) begin
      exp_rgb = pix_rgb;
    end else if (prev_de) begin
      exp_rgb.slot.hide_overscan = hide_flag;
    end
    exp_hs = 1'b0;
    if (pix_hsync && !prev_hs) begin
      hs_wait = `HSYNC_DELAY_CYCLES;
    end else if (hs_wait != 0) begin
      hs_wait = hs_wait - 1;
      exp_hs = (hs_wait == 0);
    end
    exp_vs = pix_vsync && !prev_vs;
    exp_link = ladder_for(pix_rgb, pix_hblank, pix_vblank, pix_hsync, pix_vsync);
    if (bridge_wr && bridge_addr == `CORE_ADDR_RESET) begin
      hold_left = `CORE_RESET_HOLD_CYCLES;
    end else if (hold_left != 0) begin
      hold_left = hold_left - 1;
    end
    exp_core_reset = (hold_left != 0);
    if (bridge_wr && bridge_addr == `CORE_ADDR_OVERSCAN) hide_flag = bridge_wr_data[0];
    prev_de = de;
    prev_hs = pix_hsync;
    prev_vs = pix_vsync;
  endtask

  //////////////////////////////////////////////////
  // checks

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks = checks + 1;
    assert (actual === expected) else begin
      value_errors = value_errors + 1;
      $display("error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  task automatic check_outputs();
    check_value("video_rgb", {8'h00, exp_rgb}, {8'h00, video_rgb});
    check_value("video_de", 32'(exp_de), 32'(video_de));
    check_value("video_hs", 32'(exp_hs), 32'(video_hs));
    check_value("video_vs", 32'(exp_vs), 32'(video_vs));
    check_value("link_r270", 32'(exp_link[2]), 32'(link_r270));
    check_value("link_r330", 32'(exp_link[1]), 32'(link_r330));
    check_value("link_r470", 32'(exp_link[0]), 32'(link_r470));
    check_value("core_reset", 32'(exp_core_reset), 32'(core_reset));
    // measure each core_reset pulse as it ends
    if (core_reset === 1'b1) begin
      reset_run = reset_run + 1;
    end else if (reset_run != 0) begin
      reset_pulses = reset_pulses + 1;
      assert (reset_run == `CORE_RESET_HOLD_CYCLES) else begin
        other_errors = other_errors + 1;
        $display("error at %0t: core_reset pulse length expected %0d, got %0d",
                 $time, `CORE_RESET_HOLD_CYCLES, reset_run);
      end
      reset_run = 0;
    end
  endtask

  task automatic apply_row(input row_t r);
    bridge_addr    <= r.addr;
    bridge_wr      <= (r.kind == kind_wr);
    bridge_rd      <= (r.kind == kind_rd);
    bridge_wr_data <= r.data;
    pix_rgb        <= r.rgb;
    {pix_hblank, pix_vblank, pix_hsync, pix_vsync} <= r.ctl;
  endtask

  initial begin
    clk_74a = 1'b0;
    pll_core_locked = 1'b1;
    // active video, both syncs and a reset write while the DUT is held in reset
    bridge_addr = `CORE_ADDR_RESET;
    bridge_rd = 1'b0;
    bridge_wr = 1'b1;
    bridge_wr_data = 32'h1;
    pix_rgb = 24'hffffff;
    pix_hblank = 1'b0;
    pix_vblank = 1'b0;
    pix_hsync = 1'b1;
    pix_vsync = 1'b1;
    {exp_de, exp_hs, exp_vs, exp_core_reset, exp_link} = '0;
    exp_rgb = '0;
    {prev_de, prev_hs, prev_vs, hide_flag} = '0;
    hs_wait = 0;
    hold_left = 0;
    {value_errors, other_errors, checks} = '0;
    {reset_run, reset_pulses, cycle_count, cycle_limit} = '0;
    void'($urandom(60));
    build_table();
    cycle_limit = 2 * stim_table.size() + `CORE_RESET_HOLD_CYCLES + 100;
    // falling edge once every process is waiting on it
    #1 pll_core_locked = 1'b0;
    repeat (2) @(posedge clk_74a);
    pll_core_locked <= 1'b1;
    // idle blanking inputs from the first edge out of reset
    bridge_addr <= 32'h0;
    bridge_wr <= 1'b0;
    bridge_wr_data <= 32'h0;
    pix_rgb <= '0;
    {pix_hblank, pix_vblank, pix_hsync, pix_vsync} <= 4'b1100;
    @(negedge clk_74a);
    check_outputs();
    advance_model();
    foreach (stim_table[i]) begin
      @(posedge clk_74a);
      apply_row(stim_table[i]);
      @(negedge clk_74a);
      check_outputs();
      if (stim_table[i].kind == kind_rd) begin
        check_value("bridge_rd_data", stim_table[i].exp_rd, bridge_rd_data);
      end
      advance_model();
    end
    assert (reset_pulses == 1) else begin
      other_errors = other_errors + 1;
      $display("core_reset pulsed %0d times where one pulse was due", reset_pulses);
    end
    $display("checks %0d, value errors %0d, other errors %0d", checks, value_errors,
             other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* tests/core_top_assertions.sv */
/*
  Concurrent checks bound into the glue logic top level. Watches the
  sync pulse widths and the outputs held low while the PLL is unlocked.
*/

`timescale 1ns/10ps

module core_top_assertions (
  input logic clk_74a,
  input logic pll_core_locked,
  input logic video_de,
  input logic video_hs,
  input logic video_vs,
  input logic core_reset
);

  //////////////////////////////////////////////////
  // sync pulses are one cycle wide

  hs_single: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked) video_hs |=> !video_hs
  ) else $error("video_hs stayed high for two cycles");

  vs_single: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked) video_vs |=> !video_vs
  ) else $error("video_vs stayed high for two cycles");

  // everything quiet while unlocked
  reset_quiet: assert property (
    @(posedge clk_74a) !pll_core_locked |-> !(video_de || video_hs || video_vs || core_reset)
  ) else $error("an output was high while pll_core_locked was low");

endmodule

/* source/core_top.sv */
/*
  Top level of the glue logic. Connects the bridge settings block,
  the scaler video conditioner and the link-port DAC to the host
  bridge, the incoming pixel stream and the output pins.
*/

`timescale 1ns/10ps

module core_top
  import core_pkg::*;
(
  input  logic        clk_74a,
  input  logic        pll_core_locked,

  // host bridge
  input  logic [31:0] bridge_addr,
  input  logic        bridge_rd,
  input  logic        bridge_wr,
  input  logic [31:0] bridge_wr_data,
  output logic [31:0] bridge_rd_data,

  // pixel stream from the core
  input  pixel_word_u pix_rgb,
  input  logic        pix_hblank,
  input  logic        pix_vblank,
  input  logic        pix_hsync,
  input  logic        pix_vsync,

  // scaler video
  output pixel_word_u video_rgb,
  output logic        video_de,
  output logic        video_hs,
  output logic        video_vs,

  // link-port ladder pins
  output logic        link_r270,
  output logic        link_r330,
  output logic        link_r470,

  output logic        core_reset
);

  logic hide_overscan;

  //////////////////////////////////////////////////
  // settings, bridge_rd is not needed since reads are combinational

  core_settings_regs settings0 (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd_data (bridge_rd_data),
    .core_reset     (core_reset),
    .hide_overscan  (hide_overscan)
  );

  //////////////////////////////////////////////////
  // video

  video_output video0 (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .pix_rgb        (pix_rgb),
    .pix_hblank     (pix_hblank),
    .pix_vblank     (pix_vblank),
    .pix_hsync      (pix_hsync),
    .pix_vsync      (pix_vsync),
    .hide_overscan  (hide_overscan),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs)
  );

  link_video_dac dac0 (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .pix_rgb        (pix_rgb),
    .pix_hblank     (pix_hblank),
    .pix_vblank     (pix_vblank),
    .pix_hsync      (pix_hsync),
    .pix_vsync      (pix_vsync),
    .link_r270      (link_r270),
    .link_r330      (link_r330),
    .link_r470      (link_r470)
  );

endmodule

/* source/link_video_dac.sv */
/*
  Link-port video DAC. Weights the colour into a 4-bit luma value and
  codes it onto three resistor-ladder pins (270, 330 and 470 ohm),
  with fixed black and sync levels during blanking.
*/

`timescale 1ns/10ps

`include "core_settings.svh"

module link_video_dac
  import core_pkg::*;
(
  input  logic        clk_74a,
  input  logic        pll_core_locked,
  input  pixel_word_u pix_rgb,
  input  logic        pix_hblank,
  input  logic        pix_vblank,
  input  logic        pix_hsync,
  input  logic        pix_vsync,
  output logic        link_r270,
  output logic        link_r330,
  output logic        link_r470
);

  logic [15:0] red_prod;
  logic [15:0] green_prod;
  logic [15:0] blue_prod;
  logic [15:0] luma_sum;
  logic [3:0]  luma;
  logic [2:0]  ladder_code;

  // weights add up to 0xff, so the sum never overflows
  assign red_prod   = `LUMA_WEIGHT_R * pix_rgb.colour.red;
  assign green_prod = `LUMA_WEIGHT_G * pix_rgb.colour.green;
  assign blue_prod  = `LUMA_WEIGHT_B * pix_rgb.colour.blue;
  assign luma_sum   = red_prod + green_prod + blue_prod;
  assign luma       = luma_sum[15:12];

  //////////////////////////////////////////////////
  // code order is {r270, r330, r470}

  always_comb begin
    if (luma >= `LUMA_LEVEL_5) begin
      ladder_code = 3'b110;
    end else if (luma >= `LUMA_LEVEL_4) begin
      ladder_code = 3'b101;
    end else if (luma >= `LUMA_LEVEL_3) begin
      ladder_code = 3'b011;
    end else if (luma >= `LUMA_LEVEL_2) begin
      ladder_code = 3'b100;
    end else if (luma >= `LUMA_LEVEL_1) begin
      ladder_code = 3'b010;
    end else begin
      ladder_code = 3'b001;
    end

    // black level, or sync level below it
    if (pix_hblank || pix_vblank) begin
      ladder_code = (pix_hsync || pix_vsync) ? 3'b000 : 3'b001;
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      link_r270 <= 1'b0;
      link_r330 <= 1'b0;
      link_r470 <= 1'b0;
    end else begin
      {link_r270, link_r330, link_r470} <= ladder_code;
    end
  end

endmodule

/* source/video_output.sv */
/*
  Video output conditioner for the scaler. Registers the pixel stream
  and data enable, puts the slot word on the first blanking pixel,
  and reshapes hsync and vsync into single-cycle pulses.
*/

`timescale 1ns/10ps

`include "core_settings.svh"

module video_output
  import core_pkg::*;
(
  input  logic        clk_74a,
  input  logic        pll_core_locked,
  input  pixel_word_u pix_rgb,
  input  logic        pix_hblank,
  input  logic        pix_vblank,
  input  logic        pix_hsync,
  input  logic        pix_vsync,
  input  logic        hide_overscan,
  output pixel_word_u video_rgb,
  output logic        video_de,
  output logic        video_hs,
  output logic        video_vs
);

  logic        de;
  logic        de_prev;
  logic        hs_prev;
  logic        vs_prev;
  logic [2:0]  hs_delay;
  pixel_word_u slot_word;

  assign de = !(pix_hblank || pix_vblank);

  // only the overscan bit is meaningful in the slot view
  always_comb begin
    slot_word                    = '0;
    slot_word.slot.hide_overscan = hide_overscan;
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_rgb <= '0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      de_prev   <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
      hs_delay  <= 3'd0;
    end else begin
      video_de <= de;

      if (de) begin
        video_rgb <= pix_rgb;
      end else if (de_prev) begin
        // first blanking pixel after active video
        video_rgb <= slot_word;
      end else begin
        video_rgb <= '0;
      end

      //////////////////////////////////////////////////
      // hsync, delayed so it never lands on the vsync pulse

      if (!hs_prev && pix_hsync) begin
        hs_delay <= `HSYNC_DELAY_CYCLES;
      end else if (hs_delay != 3'd0) begin
        hs_delay <= hs_delay - 3'd1;
      end
      video_hs <= (hs_delay == 3'd1);

      // vsync, one cycle on the rising edge
      video_vs <= !vs_prev && pix_vsync;

      de_prev <= de;
      hs_prev <= pix_hsync;
      vs_prev <= pix_vsync;
    end
  end

endmodule

/* source/core_settings_regs.sv */
/*
  Host bridge settings registers. Decodes bridge writes into the core
  reset hold counter and the hide-overscan flag, and answers bridge
  reads combinationally from the same map.
*/

`timescale 1ns/10ps

`include "core_settings.svh"

module core_settings_regs (
  input  logic        clk_74a,
  input  logic        pll_core_locked,
  input  logic [31:0] bridge_addr,
  input  logic        bridge_wr,
  input  logic [31:0] bridge_wr_data,
  output logic [31:0] bridge_rd_data,
  output logic        core_reset,
  output logic        hide_overscan
);

  localparam int HOLD_W = $clog2(`CORE_RESET_HOLD_CYCLES + 1);

  logic [HOLD_W-1:0] hold_cnt;
  logic              wr_reset;
  logic              wr_overscan;

  assign wr_reset    = bridge_wr && (bridge_addr == `CORE_ADDR_RESET);
  assign wr_overscan = bridge_wr && (bridge_addr == `CORE_ADDR_OVERSCAN);

  //////////////////////////////////////////////////
  // write side

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_cnt      <= '0;
      hide_overscan <= 1'b0;
    end else begin
      // a new reset write restarts the hold
      if (wr_reset) begin
        hold_cnt <= HOLD_W'(`CORE_RESET_HOLD_CYCLES);
      end else if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end

      if (wr_overscan) begin
        hide_overscan <= bridge_wr_data[0];
      end
    end
  end

  assign core_reset = (hold_cnt != '0);

  //////////////////////////////////////////////////
  // read side, no wait states

  always_comb begin
    bridge_rd_data = 32'h0;
    if (bridge_addr == `CORE_ADDR_OVERSCAN) begin
      bridge_rd_data[0] = hide_overscan;
    end
  end

endmodule

/* source/core_pkg.sv */
/*
  Shared types for the video path of the console glue logic.
  The pixel word travels as one 24-bit union so that the scaler
  slot word and the colour word use the same wires.
*/

package core_pkg;

  ///////////////////////////////////////////////////
  // pixel word, colour view and slot-information view

  typedef union packed {
    // normal pixel, red in the top byte
    struct packed {
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
    } colour;
    // sent on the first blanking pixel of a line
    struct packed {
      logic [9:0]  rsvd_hi;
      logic        hide_overscan;
      logic [12:0] rsvd_lo;
    } slot;
  } pixel_word_u;

endpackage

/* source/core_settings.svh */
/*
  Fixed settings of the glue logic: bridge register map, core reset
  hold time, luma weights and thresholds for the link-port DAC, and
  the hsync delay. Include where the values are needed.
*/

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// bridge register map
`define CORE_ADDR_RESET        32'h0000_0050
`define CORE_ADDR_OVERSCAN     32'h0000_0200

// cycles that core_reset stays high after a reset write
`define CORE_RESET_HOLD_CYCLES 64

// luma weights, roughly 0.30 / 0.59 / 0.11 in 8-bit fixed point
`define LUMA_WEIGHT_R          8'h4C
`define LUMA_WEIGHT_G          8'h97
`define LUMA_WEIGHT_B          8'h1C

// luma thresholds for the resistor ladder, darkest to brightest
`define LUMA_LEVEL_1           4'd2
`define LUMA_LEVEL_2           4'd4
`define LUMA_LEVEL_3           4'd6
`define LUMA_LEVEL_4           4'd9
`define LUMA_LEVEL_5           4'd12

// hsync pulse is moved this many edges after the rising edge
`define HSYNC_DELAY_CYCLES     3'd7

`endif
